// File: sfx_top.f
+incdir+common
common/sfx_pkg.sv
common/tone_if.sv
verilog/sfx_regs.sv
verilog/collision_arbiter.sv
oscillator/oscillator.sv
verilog/speaker_driver.sv
verilog/sfx_top.sv
testbench/sfx_properties.sv
testbench/sfx_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sfx_top_tb
FILELIST  ?= sfx_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/sfx_top_tb.sv
`default_nettype none

`include "sfx_macros.svh"

module sfx_top_tb import sfx_pkg::*; ();

    localparam int PERIOD   = 100;
    localparam int GOOD_DIV = 3;
    localparam int GOOD_DUR = 40;
    localparam int BAD_DIV  = 4;
    localparam int BAD_DUR  = 27;
    // three good tones and one bad tone are played
    localparam int CYCLE_LIMIT = 3 * GOOD_DUR + BAD_DUR + 2000;

    logic      clk;
    logic      nRst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    mode_t     mode;
    logic      good_coll;
    logic      bad_coll;
    logic      speaker;
    logic      sound_active;

    integer    seed = 28322;
    int        cycles = 0;
    int        toggles = 0;   // speaker edges inside a tone
    int        tones = 0;     // rising edges of sound_active
    logic      speaker_q = 1'b0;
    logic      active_q = 1'b0;
    int        toggles_start;
    int        tones_start;
    int        gap;
    apb_data_t rdata;
    logic      err;

    sfx_top DUT (
        .clk          (clk),
        .nRst         (nRst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .mode         (mode),
        .good_coll    (good_coll),
        .bad_coll     (bad_coll),
        .speaker      (speaker),
        .sound_active (sound_active)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (speaker != speaker_q && sound_active) begin
            toggles <= toggles + 1; // the drop back to 0 at tone end is not a toggle
        end
        if (sound_active && !active_q) begin
            tones <= tones + 1;
        end
        speaker_q <= speaker;
        active_q  <= sound_active;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: no end of test after %0d cycles", cycles);
            $display("Test failures found");
            $fatal(1, "cycle limit reached");
        end
    end

    // one tick every div+1 cycles of the duration
    function automatic int expected_toggles(input int div, input int dur);
        return dur / (div + 1);
    endfunction

    task automatic check_value(input string what, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("mismatch at time %0t: %s is %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t data,
                              output apb_data_t rd, output logic slverr);
        @(negedge clk);
        psel   = 1'b1; // setup phase
        pwrite = write;
        paddr  = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        #(PERIOD / 4);
        rd      = prdata; // access phase, ahead of the transfer edge
        slverr  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_access(1'b1, addr, data, rdata, err);
        check_value("pslverr on write", int'(err), 0);
    endtask

    task automatic read_check(input apb_addr_t addr, input int expected, input string what);
        apb_access(1'b0, addr, '0, rdata, err);
        check_value("pslverr on read", int'(err), 0);
        check_value(what, rdata, expected);
    endtask

    task automatic pulse_collision(input logic good, input logic bad);
        @(negedge clk);
        good_coll = good;
        bad_coll  = bad;
        @(negedge clk);
        good_coll = 1'b0;
        bad_coll  = 1'b0;
    endtask

    task automatic wait_tone_start();
        while (!sound_active) @(negedge clk);
    endtask

    task automatic wait_tone_end();
        wait_tone_start();
        while (sound_active) @(negedge clk);
    endtask

    task automatic mark_counts();
        toggles_start = toggles;
        tones_start   = tones;
    endtask

    initial begin
        nRst      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        mode      = MODE_IDLE;
        good_coll = 1'b0;
        bad_coll  = 1'b0;
        repeat (4) @(negedge clk);
        nRst = 1'b1;

        // reset values and bus errors
        read_check(`SFX_ADDR_CTRL, 1, "ctrl after reset");
        read_check(`SFX_ADDR_GOOD_DIV, int'(`SFX_GOOD_DIV_RST), "good_div after reset");
        read_check(`SFX_ADDR_BAD_DIV, int'(`SFX_BAD_DIV_RST), "bad_div after reset");
        read_check(`SFX_ADDR_GOOD_DUR, int'(`SFX_GOOD_DUR_RST), "good_dur after reset");
        read_check(`SFX_ADDR_BAD_DUR, int'(`SFX_BAD_DUR_RST), "bad_dur after reset");
        read_check(`SFX_ADDR_TONE_COUNT, 0, "tone count after reset");
        apb_access(1'b0, 8'h18, '0, rdata, err);
        check_value("pslverr on unmapped read", int'(err), 1);
        apb_access(1'b1, `SFX_ADDR_TONE_COUNT, 32'h5, rdata, err);
        check_value("pslverr on tone count write", int'(err), 1);
        read_check(`SFX_ADDR_TONE_COUNT, 0, "tone count after refused write");

        // one short good tone
        write_reg(`SFX_ADDR_GOOD_DIV, GOOD_DIV);
        write_reg(`SFX_ADDR_GOOD_DUR, GOOD_DUR);
        mode = MODE_PLAY;
        mark_counts();
        pulse_collision(1'b1, 1'b0);
        wait_tone_end();
        check_value("good tone toggles", toggles - toggles_start,
                    expected_toggles(GOOD_DIV, GOOD_DUR));
        read_check(`SFX_ADDR_TONE_COUNT, 1, "tone count after good tone");

        // bad beats good in the same cycle
        write_reg(`SFX_ADDR_BAD_DIV, BAD_DIV);
        write_reg(`SFX_ADDR_BAD_DUR, BAD_DUR);
        mark_counts();
        pulse_collision(1'b1, 1'b1);
        wait_tone_end();
        check_value("bad tone toggles", toggles - toggles_start,
                    expected_toggles(BAD_DIV, BAD_DUR));
        read_check(`SFX_ADDR_TONE_COUNT, 2, "tone count after bad tone");

        // collisions dropped while paused and while disabled
        mark_counts();
        mode = MODE_PAUSE;
        pulse_collision(1'b1, 1'b0);
        pulse_collision(1'b0, 1'b1);
        repeat (20) @(negedge clk);
        mode = MODE_PLAY;
        write_reg(`SFX_ADDR_CTRL, 32'h0);
        pulse_collision(1'b1, 1'b1);
        repeat (20) @(negedge clk);
        check_value("tones while paused or disabled", tones - tones_start, 0);
        check_value("toggles while paused or disabled", toggles - toggles_start, 0);
        read_check(`SFX_ADDR_TONE_COUNT, 2, "tone count after dropped collisions");

        // collisions during a running tone are dropped
        write_reg(`SFX_ADDR_CTRL, 32'h1);
        mark_counts();
        pulse_collision(1'b1, 1'b0);
        wait_tone_start();
        repeat (3) begin
            gap = 1 + ($unsigned($random(seed)) % 3);
            repeat (gap) @(negedge clk);
            pulse_collision(1'b0, 1'b1);
        end
        wait_tone_end();
        repeat (20) @(negedge clk);
        check_value("tones with collisions while busy", tones - tones_start, 1);
        check_value("toggles with collisions while busy", toggles - toggles_start,
                    expected_toggles(GOOD_DIV, GOOD_DUR));
        read_check(`SFX_ADDR_TONE_COUNT, 3, "tone count after busy collisions");

        // muted tone runs silently
        write_reg(`SFX_ADDR_CTRL, 32'h3);
        mark_counts();
        pulse_collision(1'b1, 1'b0);
        wait_tone_end();
        check_value("muted tones", tones - tones_start, 1);
        check_value("muted toggles", toggles - toggles_start, 0);
        read_check(`SFX_ADDR_TONE_COUNT, 4, "tone count after muted tone");

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/sfx_properties.sv
`default_nettype none

module sfx_properties import sfx_pkg::*; (
    input logic  clk,
    input logic  nRst,
    input mode_t mode,
    input logic  good_coll,
    input logic  bad_coll,
    input logic  pready,
    input logic  speaker,
    input logic  sound_active
);

    logic coll_pending; // play-mode collision not yet heard
    logic active_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            coll_pending <= 1'b0;
            active_q     <= 1'b0;
        end else begin
            active_q <= sound_active;
            if ((good_coll || bad_coll) && mode == MODE_PLAY) begin
                coll_pending <= 1'b1;
            end else if (sound_active && !active_q) begin
                coll_pending <= 1'b0; // used up by the tone that just started
            end
        end
    end

    silent_when_idle: assert property (@(posedge clk) disable iff (!nRst)
        !sound_active |-> !speaker)
        else $error("speaker is high while no tone is active");

    no_wait_states: assert property (@(posedge clk) disable iff (!nRst)
        pready)
        else $error("pready dropped low");

    // a tone only follows a collision taken in play mode
    tone_has_cause: assert property (@(posedge clk) disable iff (!nRst)
        $rose(sound_active) |-> coll_pending)
        else $error("sound started without a play-mode collision");

endmodule

bind sfx_top sfx_properties u_props (
    .clk          (clk),
    .nRst         (nRst),
    .mode         (mode),
    .good_coll    (good_coll),
    .bad_coll     (bad_coll),
    .pready       (pready),
    .speaker      (speaker),
    .sound_active (sound_active)
);

`default_nettype wire

// File: verilog/sfx_top.sv
`default_nettype none

module sfx_top import sfx_pkg::*; (
    input  logic      clk,
    input  logic      nRst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    input  mode_t     mode,
    input  logic      good_coll,
    input  logic      bad_coll,
    output logic      speaker,
    output logic      sound_active
);

    logic      enable;
    logic      mute;
    divisor_t  good_div;
    divisor_t  bad_div;
    duration_t good_dur;
    duration_t bad_dur;
    logic      tick;
    logic      busy;
    logic      tone_done;

    tone_if tone_req ();

    sfx_regs u_regs (
        .clk       (clk),
        .nRst      (nRst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .tone_done (tone_done),
        .enable    (enable),
        .mute      (mute),
        .good_div  (good_div),
        .bad_div   (bad_div),
        .good_dur  (good_dur),
        .bad_dur   (bad_dur)
    );

    collision_arbiter u_arbiter (
        .clk       (clk),
        .nRst      (nRst),
        .mode      (mode),
        .good_coll (good_coll),
        .bad_coll  (bad_coll),
        .enable    (enable),
        .good_div  (good_div),
        .bad_div   (bad_div),
        .good_dur  (good_dur),
        .bad_dur   (bad_dur),
        .req       (tone_req.src)
    );

    oscillator u_osc (
        .clk       (clk),
        .nRst      (nRst),
        .req       (tone_req.dst),
        .tick      (tick),
        .busy      (busy),
        .tone_done (tone_done)
    );

    speaker_driver u_spk (
        .clk          (clk),
        .nRst         (nRst),
        .tick         (tick),
        .busy         (busy),
        .mute         (mute),
        .speaker      (speaker),
        .sound_active (sound_active)
    );

endmodule

`default_nettype wire

// File: verilog/speaker_driver.sv
`default_nettype none

module speaker_driver (
    input  logic clk,
    input  logic nRst,
    input  logic tick,
    input  logic busy,
    input  logic mute,
    output logic speaker,
    output logic sound_active
);

    // square wave, one edge per tick
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            speaker <= 1'b0;
        end else if (!busy || mute) begin
            speaker <= 1'b0; // silence
        end else if (tick) begin
            speaker <= ~speaker;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            sound_active <= 1'b0;
        end else begin
            sound_active <= busy; // one cycle behind the oscillator
        end
    end

endmodule

`default_nettype wire

// File: oscillator/oscillator.sv
`default_nettype none

module oscillator import sfx_pkg::*; (
    input  logic clk,
    input  logic nRst,
    tone_if.dst  req,
    output logic tick,
    output logic busy,
    output logic tone_done
);

    osc_state_t state, state_nxt;
    divisor_t   div_q;
    divisor_t   pitch_cnt, pitch_cnt_nxt;
    duration_t  dur_q;
    duration_t  stay_cnt, stay_cnt_nxt;
    logic       period_end;
    logic       last_cycle;

    assign req.ready = (state == OSC_IDLE);
    assign busy      = (state == OSC_RUN);

    assign period_end = (pitch_cnt == div_q);
    // a zero duration still runs for one cycle
    assign last_cycle = (dur_q == '0) || (stay_cnt == dur_q - duration_t'(1));
    assign tick       = busy && period_end && (dur_q != '0);

    always_comb begin
        state_nxt     = state;
        pitch_cnt_nxt = pitch_cnt;
        stay_cnt_nxt  = stay_cnt;
        case (state)
            OSC_IDLE: begin
                if (req.valid) begin
                    state_nxt     = OSC_RUN;
                    pitch_cnt_nxt = '0;
                    stay_cnt_nxt  = '0;
                end
            end
            OSC_RUN: begin
                if (last_cycle) begin
                    state_nxt = OSC_IDLE;
                end
                stay_cnt_nxt  = stay_cnt + duration_t'(1);
                pitch_cnt_nxt = period_end ? '0 : pitch_cnt + divisor_t'(1);
            end
            default: state_nxt = OSC_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= OSC_IDLE;
            pitch_cnt <= '0;
            stay_cnt  <= '0;
            tone_done <= 1'b0;
        end else begin
            state     <= state_nxt;
            pitch_cnt <= pitch_cnt_nxt;
            stay_cnt  <= stay_cnt_nxt;
            tone_done <= busy && last_cycle; // high once busy is gone
        end
    end

    // request payload, taken on the transfer edge
    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            div_q <= req.divisor;
            dur_q <= req.duration;
        end
    end

endmodule

`default_nettype wire

// File: verilog/collision_arbiter.sv
`default_nettype none

module collision_arbiter import sfx_pkg::*; (
    input  logic      clk,
    input  logic      nRst,
    input  mode_t     mode,
    input  logic      good_coll,
    input  logic      bad_coll,
    input  logic      enable,
    input  divisor_t  good_div,
    input  divisor_t  bad_div,
    input  duration_t good_dur,
    input  duration_t bad_dur,
    tone_if.src       req
);

    logic      valid_q;
    divisor_t  div_q;
    duration_t dur_q;
    logic      accept;
    logic      xfer;

    // only one slot, and only while the oscillator is free
    assign accept = (mode == MODE_PLAY) && enable && !valid_q && req.ready
                    && (good_coll || bad_coll);
    assign xfer   = valid_q && req.ready;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (xfer) begin
            valid_q <= 1'b0; // oscillator took it
        end
    end

    // tone settings frozen at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            if (bad_coll) begin
                div_q <= bad_div; // bad beats good
                dur_q <= bad_dur;
            end else begin
                div_q <= good_div;
                dur_q <= good_dur;
            end
        end
    end

    assign req.valid    = valid_q;
    assign req.divisor  = div_q;
    assign req.duration = dur_q;

endmodule

`default_nettype wire

// File: verilog/sfx_regs.sv
`default_nettype none

`include "sfx_macros.svh"

module sfx_regs import sfx_pkg::*; (
    input  logic      clk,
    input  logic      nRst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    input  logic      tone_done,
    output logic      enable,
    output logic      mute,
    output divisor_t  good_div,
    output divisor_t  bad_div,
    output duration_t good_dur,
    output duration_t bad_dur
);

    logic        access;
    logic        wr_en;
    logic        addr_hit;
    logic        ro_hit;
    tone_count_t tone_count;

    assign access = psel && penable; // second cycle of the transfer
    assign wr_en  = access && pwrite && addr_hit && !ro_hit;

    // read mux and address decode
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        ro_hit   = 1'b0;
        case (paddr)
            `SFX_ADDR_CTRL: begin
                prdata[`SFX_CTRL_ENABLE_BIT] = enable;
                prdata[`SFX_CTRL_MUTE_BIT]   = mute;
            end
            `SFX_ADDR_GOOD_DIV:   prdata = apb_data_t'(good_div);
            `SFX_ADDR_BAD_DIV:    prdata = apb_data_t'(bad_div);
            `SFX_ADDR_GOOD_DUR:   prdata = apb_data_t'(good_dur);
            `SFX_ADDR_BAD_DUR:    prdata = apb_data_t'(bad_dur);
            `SFX_ADDR_TONE_COUNT: begin
                prdata = apb_data_t'(tone_count);
                ro_hit = 1'b1; // counter is read-only
            end
            default: addr_hit = 1'b0;
        endcase
    end

    assign pready  = 1'b1; // no wait states
    assign pslverr = access && (!addr_hit || (pwrite && ro_hit));

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            enable   <= 1'b1; // sound on out of reset
            mute     <= 1'b0;
            good_div <= `SFX_GOOD_DIV_RST;
            bad_div  <= `SFX_BAD_DIV_RST;
            good_dur <= `SFX_GOOD_DUR_RST;
            bad_dur  <= `SFX_BAD_DUR_RST;
        end else if (wr_en) begin
            case (paddr)
                `SFX_ADDR_CTRL: begin
                    enable <= pwdata[`SFX_CTRL_ENABLE_BIT];
                    mute   <= pwdata[`SFX_CTRL_MUTE_BIT];
                end
                `SFX_ADDR_GOOD_DIV: good_div <= pwdata[7:0];
                `SFX_ADDR_BAD_DIV:  bad_div  <= pwdata[7:0];
                `SFX_ADDR_GOOD_DUR: good_dur <= pwdata[23:0];
                `SFX_ADDR_BAD_DUR:  bad_dur  <= pwdata[23:0];
                default: ;
            endcase
        end
    end

    // completed tones
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            tone_count <= '0;
        end else if (tone_done) begin
            tone_count <= tone_count + tone_count_t'(1); // wraps at 16 bits
        end
    end

endmodule

`default_nettype wire

// File: common/tone_if.sv
`default_nettype none

interface tone_if import sfx_pkg::*; ();

    logic      valid;    // request pending
    logic      ready;    // oscillator idle
    divisor_t  divisor;  // pitch of the tone
    duration_t duration; // length in cycles

    modport src (
        output valid,
        output divisor,
        output duration,
        input  ready
    );

    modport dst (
        input  valid,
        input  divisor,
        input  duration,
        output ready
    );

endinterface

`default_nettype wire

// File: common/sfx_pkg.sv
`default_nettype none

package sfx_pkg;

    // pitch divisor, one tick every divisor+1 cycles
    typedef logic [7:0] divisor_t;

    // tone length in clock cycles
    typedef logic [23:0] duration_t;

    typedef logic [15:0] tone_count_t; // completed tones, wraps

    typedef logic [7:0] apb_addr_t;  // register byte address
    typedef logic [31:0] apb_data_t; // register data

    // game state coming from the game logic
    typedef enum logic [1:0] {
        MODE_IDLE  = 2'd0,
        MODE_PLAY  = 2'd1,
        MODE_PAUSE = 2'd2,
        MODE_OVER  = 2'd3
    } mode_t;

    typedef enum logic {
        OSC_IDLE = 1'b0,
        OSC_RUN  = 1'b1
    } osc_state_t;

endpackage

`default_nettype wire

// File: common/sfx_macros.svh
`ifndef SFX_MACROS_SVH
`define SFX_MACROS_SVH

// register map, byte addresses
`define SFX_ADDR_CTRL       8'h00
`define SFX_ADDR_GOOD_DIV   8'h04
`define SFX_ADDR_BAD_DIV    8'h08
`define SFX_ADDR_GOOD_DUR   8'h0C
`define SFX_ADDR_BAD_DUR    8'h10
`define SFX_ADDR_TONE_COUNT 8'h14

// control register bits
`define SFX_CTRL_ENABLE_BIT 0
`define SFX_CTRL_MUTE_BIT   1

// reset tone settings for a 12 MHz clock
`define SFX_GOOD_DIV_RST    8'd36
`define SFX_BAD_DIV_RST     8'd188
`define SFX_GOOD_DUR_RST    24'd3000000
`define SFX_BAD_DUR_RST     24'd10000000

`endif
